// File: hdl/island_bootrom.hex
// One 32-bit boot ROM word per line, word 0 first
00000093
00000113
002001b7
0001a203
00100293
0051a223
000012b7
0002a303
00030463
0000006f
00430313
0061a023
10500073
ffdff06f
badcab1e
00008067

// File: filelist.f
+incdir+sim
hdl/island_pkg.sv
hdl/island_sram_bank.sv
hdl/island_bootrom.sv
hdl/island_soc_ctrl.sv
hdl/island_periph_demux.sv
hdl/island_xbar.sv
hdl/island_top.sv
sim/tb_island.sv

// File: Makefile
TOP := tb_island

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// File: sim/tb_island_checks.svh
// Compare tasks, the LCG generator and the grant and drain wait loops
`ifndef TB_ISLAND_CHECKS_SVH
`define TB_ISLAND_CHECKS_SVH

task automatic check_rsp(input string what, input bus_rsp_t exp, input bus_rsp_t act);
  if (act !== exp) begin
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
    abort_run();
  end
endtask

task automatic check_word(input string what, input logic [AddrWidth-1:0] exp,
                          input logic [AddrWidth-1:0] act);
  if (act !== exp) begin
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    abort_run();
  end
endtask

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Returns at the falling edge where the grant is seen
task automatic wait_grant(input int m);
  int unsigned n;
  n = 0;
  @(negedge clk);
  while (!gnt[m]) begin
    n++;
    if (n > WaitLimit) begin
      $display("Timeout in %s: master %0d never got a grant", test_name, m);
      abort_run();
    end else begin
      @(negedge clk);
    end
  end
endtask

task automatic wait_drain();
  int unsigned n;
  n = 0;
  while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
    n++;
    if (n > WaitLimit) begin
      $display("Timeout in %s: responses still outstanding", test_name);
      abort_run();
    end else begin
      @(negedge clk);
    end
  end
endtask

`endif

// File: sim/tb_island.sv
// Island testbench with clock, reset, reference model, response checker and test sequence
`timescale 1ns/100ps

module tb_island import island_pkg::*; ();

  localparam int unsigned WaitLimit  = 64;
  localparam int unsigned BankWords  = BankNumBytes / BeWidth;
  localparam int unsigned NumAddr    = 16;
  localparam int unsigned ContendLen = 10;

  typedef struct {
    bus_rsp_t    rsp;
    logic        chk_data;
    int unsigned cyc;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  boot_mode_e           bootmode;
  logic                 req    [NumMasters];
  bus_req_t             data   [NumMasters];
  logic                 gnt    [NumMasters];
  logic                 rvalid [NumMasters];
  bus_rsp_t             rsp    [NumMasters];
  logic                 fetch_en;
  logic [AddrWidth-1:0] boot_addr;

  int unsigned          cyc;
  string                test_name;
  logic [31:0]          lcg_state;
  exp_t                 exp_q [NumMasters][$];
  int                   gnt_order [$];
  logic                 log_grants;
  logic [DataWidth-1:0] ref_mem [NumBanks][BankWords];
  logic [DataWidth-1:0] ref_rom [RomNumWords];
  logic [AddrWidth-1:0] ref_boot_addr;
  logic                 ref_fetch_en;
  boot_mode_e           ref_boot_mode;
  logic [AddrWidth-1:0] addr_list [NumAddr];

  island_top dut (
    .clk_i          ( clk       ),
    .rst_ni         ( rst_n     ),
    .bootmode_i     ( bootmode  ),
    .m_req_i        ( req       ),
    .m_data_i       ( data      ),
    .m_gnt_o        ( gnt       ),
    .m_rvalid_o     ( rvalid    ),
    .m_rsp_o        ( rsp       ),
    .fetch_enable_o ( fetch_en  ),
    .boot_addr_o    ( boot_addr )
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_island_checks.svh"

  // -------------------------------------------------------------------
  // Reference model of banks, control registers, ROM and error target
  // -------------------------------------------------------------------
  function automatic exp_t ref_access(input bus_req_t d);
    exp_t                 e;
    int unsigned          bank;
    int unsigned          widx;
    logic [AddrWidth-1:0] off;
    e.rsp      = '{rdata: '0, err: 1'b0};
    e.chk_data = !d.we;
    e.cyc      = 0;
    off        = d.addr - IslandBase;
    if (off < NumBanks * BankNumBytes) begin
      bank = off / BankNumBytes;
      widx = (off % BankNumBytes) / BeWidth;
      for (int b = 0; b < BeWidth; b++) begin
        if (d.we && d.be[b]) begin
          ref_mem[bank][widx][8*b +: 8] = d.wdata[8*b +: 8];
        end
      end
      e.rsp.rdata = ref_mem[bank][widx];
    end else if (d.addr - PeriphBase - SocCtrlOffset < SocCtrlRange) begin
      off = d.addr - PeriphBase - SocCtrlOffset;
      if (d.we && off == RegBootAddr) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (d.be[b]) begin
            ref_boot_addr[8*b +: 8] = d.wdata[8*b +: 8];
          end
        end
      end else if (d.we && off == RegFetchEn && d.be[0]) begin
        ref_fetch_en = d.wdata[0];
      end else if (off == RegBootAddr) begin
        e.rsp.rdata = ref_boot_addr;
      end else if (off == RegFetchEn) begin
        e.rsp.rdata = {31'b0, ref_fetch_en};
      end else if (off == RegBootMode) begin
        e.rsp.rdata = {30'b0, ref_boot_mode};
      end
    end else if (d.addr - PeriphBase - BootRomOffset < BootRomRange) begin
      // ROM repeats every sixteen words
      e.rsp.rdata = ref_rom[(d.addr / BeWidth) % RomNumWords];
      e.rsp.err   = d.we;
    end else begin
      e.rsp      = '{rdata: ErrorRdata, err: 1'b1};
      e.chk_data = 1'b1;
    end
    return e;
  endfunction

  function automatic bus_req_t make_req(input logic we, input logic [BeWidth-1:0] be,
                                        input logic [AddrWidth-1:0] addr,
                                        input logic [DataWidth-1:0] wdata);
    return '{we: we, be: be, addr: addr, wdata: wdata};
  endfunction

  // -------------------------------------------------------------------
  // Master drivers
  // -------------------------------------------------------------------
  // Starts right after a rising edge and ends on the transfer edge
  task automatic transfer(input int m, input bus_req_t d);
    exp_t e;
    req[m]  <= 1'b1;
    data[m] <= d;
    wait_grant(m);
    e     = ref_access(d);
    e.cyc = cyc;
    exp_q[m].push_back(e);
    if (log_grants) begin
      gnt_order.push_back(m);
    end
    @(posedge clk);
  endtask

  task automatic single_transfer(input int m, input bus_req_t d);
    @(posedge clk);
    transfer(m, d);
    req[m] <= 1'b0;
  endtask

  task automatic read_stream(input int m, input logic [AddrWidth-1:0] base);
    @(posedge clk);
    for (int i = 0; i < ContendLen; i++) begin
      transfer(m, make_req(1'b0, '0, base + AddrWidth'(4 * i), '0));
    end
    req[m] <= 1'b0;
  endtask

  // Every response must come one cycle after its grant
  always @(negedge clk) begin : compare_responses
    exp_t e;
    if (rst_n) begin
      for (int m = 0; m < NumMasters; m++) begin
        if (rvalid[m] && exp_q[m].size() == 0) begin
          $display("Master %0d got a response it never asked for", m);
          abort_run();
        end else if (rvalid[m]) begin
          e = exp_q[m].pop_front();
          if (cyc != e.cyc + 1) begin
            $display("Master %0d response came %0d cycles after its grant", m, cyc - e.cyc);
            abort_run();
          end else if (e.chk_data) begin
            check_rsp("response", e.rsp, rsp[m]);
          end else begin
            check_bit("error flag", e.rsp.err, rsp[m].err);
          end
        end else if (exp_q[m].size() != 0 && exp_q[m][0].cyc + 1 < cyc) begin
          $display("Master %0d is missing a response in %s", m, test_name);
          abort_run();
        end
      end
    end
  end

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------
  initial begin : test_sequence
    logic [AddrWidth-1:0] a;
    clk        = 1'b0;
    rst_n      = 1'b0;
    bootmode   = BOOT_JTAG;
    cyc        = 0;
    lcg_state  = 32'd90;
    log_grants = 1'b0;
    test_name  = "reset";
    for (int m = 0; m < NumMasters; m++) begin
      req[m]  = 1'b0;
      data[m] = '0;
    end
    $readmemh(BootRomFile, ref_rom);
    ref_boot_addr = PeriphBase + BootRomOffset;
    ref_boot_mode = bootmode;
    ref_fetch_en  = (bootmode == BOOT_JTAG);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // Boot mode capture takes one cycle after release
    repeat (2) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      for (int m = 0; m < NumMasters; m++) begin
        check_bit("idle grant", 1'b0, gnt[m]);
        check_bit("idle response valid", 1'b0, rvalid[m]);
      end
    end
    check_bit("fetch_enable_o", ref_fetch_en, fetch_en);
    check_word("boot_addr_o", ref_boot_addr, boot_addr);

    test_name = "bank";
    for (int b = 0; b < NumBanks; b++) begin
      for (int i = 0; i < NumAddr; i++) begin
        addr_list[i] = IslandBase + AddrWidth'(b) * BankNumBytes
                       + ((lcg_next() >> 8) % BankWords) * BeWidth;
        single_transfer(i % 2, make_req(1'b1, 4'hF, addr_list[i], lcg_next()));
      end
      for (int i = 0; i < NumAddr; i++) begin
        single_transfer((i + 1) % 2,
                        make_req(1'b1, 4'(lcg_next() >> 12), addr_list[i], lcg_next()));
      end
      for (int i = 0; i < NumAddr; i++) begin
        single_transfer(i % 2, make_req(1'b0, '0, addr_list[i], '0));
      end
    end
    wait_drain();

    test_name = "contention";
    a = IslandBase + BankNumBytes;
    for (int i = 0; i < ContendLen; i++) begin
      single_transfer(0, make_req(1'b1, 4'hF, a + 32'h100 + 4 * i, 32'hA5A5_0000 + i));
      single_transfer(1, make_req(1'b1, 4'hF, a + 32'h200 + 4 * i, 32'h5A5A_0000 + i));
    end
    wait_drain();
    log_grants = 1'b1;
    fork
      read_stream(0, a + 32'h100);
      read_stream(1, a + 32'h200);
    join
    log_grants = 1'b0;
    wait_drain();
    if (gnt_order.size() != 2 * ContendLen) begin
      $display("Contention granted %0d transfers instead of %0d", gnt_order.size(),
               2 * ContendLen);
      abort_run();
    end else begin
      for (int i = 1; i < gnt_order.size(); i++) begin
        if (gnt_order[i] == gnt_order[i-1]) begin
          $display("Round-robin broken, master %0d won twice in a row", gnt_order[i]);
          abort_run();
        end
      end
    end

    test_name = "soc_ctrl";
    a = PeriphBase + SocCtrlOffset;
    single_transfer(0, make_req(1'b1, 4'hF, a + RegBootAddr, 32'h1C00_0080));
    single_transfer(1, make_req(1'b1, 4'b0011, a + RegBootAddr, 32'hFFFF_5A5A));
    single_transfer(0, make_req(1'b1, 4'h1, a + RegFetchEn, 32'h0));
    single_transfer(1, make_req(1'b0, '0, a + RegBootAddr, '0));
    single_transfer(0, make_req(1'b0, '0, a + RegFetchEn, '0));
    single_transfer(1, make_req(1'b1, 4'hF, a + RegBootMode, 32'(BOOT_UART)));
    single_transfer(0, make_req(1'b0, '0, a + RegBootMode, '0));
    wait_drain();
    check_word("boot_addr_o", ref_boot_addr, boot_addr);
    check_bit("fetch_enable_o", ref_fetch_en, fetch_en);

    test_name = "bootrom";
    a = PeriphBase + BootRomOffset;
    for (int i = 0; i < RomNumWords; i++) begin
      single_transfer(i % 2, make_req(1'b0, '0, a + 4 * i, '0));
    end
    single_transfer(0, make_req(1'b0, '0, a + 32'h44, '0));
    single_transfer(1, make_req(1'b1, 4'hF, a + 32'h8, 32'hDEAD_BEEF));

    test_name = "error";
    single_transfer(0, make_req(1'b0, '0, PeriphBase + 32'h3000, '0));
    single_transfer(1, make_req(1'b1, 4'hF, PeriphBase + 32'h8000, 32'h1234_5678));
    single_transfer(0, make_req(1'b0, '0, IslandBase + 2 * BankNumBytes, '0));
    single_transfer(1, make_req(1'b0, '0, 32'h1000_0000, '0));
    single_transfer(0, make_req(1'b1, 4'h3, 32'hFFFF_FFF0, 32'h0000_FFFF));
    wait_drain();

    $display("TEST OK");
    $finish;
  end

endmodule

// File: hdl/island_top.sv
// Island top level connecting two master ports to the SRAM banks and peripherals
`timescale 1ns/100ps

module island_top import island_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  boot_mode_e           bootmode_i,

  input  logic                 m_req_i    [NumMasters],
  input  bus_req_t             m_data_i   [NumMasters],
  output logic                 m_gnt_o    [NumMasters],
  output logic                 m_rvalid_o [NumMasters],
  output bus_rsp_t             m_rsp_o    [NumMasters],

  output logic                 fetch_enable_o,
  output logic [AddrWidth-1:0] boot_addr_o
);

  logic     tgt_req  [NumTargets];
  bus_req_t tgt_data [NumTargets];
  logic     tgt_gnt  [NumTargets];
  bus_rsp_t tgt_rsp  [NumTargets];

  island_xbar #(
    .NumIn  ( NumMasters ),
    .NumOut ( NumTargets )
  ) i_xbar (
    .clk_i,
    .rst_ni,
    .in_req_i    ( m_req_i    ),
    .in_data_i   ( m_data_i   ),
    .in_gnt_o    ( m_gnt_o    ),
    .in_rvalid_o ( m_rvalid_o ),
    .in_rsp_o    ( m_rsp_o    ),
    .out_req_o   ( tgt_req    ),
    .out_data_o  ( tgt_data   ),
    .out_gnt_i   ( tgt_gnt    ),
    .out_rsp_i   ( tgt_rsp    )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    island_sram_bank i_bank (
      .clk_i,
      .rst_ni,
      .req_i    ( tgt_req[TgtBank0+b]  ),
      .data_i   ( tgt_data[TgtBank0+b] ),
      .gnt_o    ( tgt_gnt[TgtBank0+b]  ),
      .rvalid_o (                      ),
      .rsp_o    ( tgt_rsp[TgtBank0+b]  )
    );
  end

  island_periph_demux i_periph (
    .clk_i,
    .rst_ni,
    .req_i          ( tgt_req[TgtPeriph]  ),
    .data_i         ( tgt_data[TgtPeriph] ),
    .gnt_o          ( tgt_gnt[TgtPeriph]  ),
    .rvalid_o       (                     ),
    .rsp_o          ( tgt_rsp[TgtPeriph]  ),
    .fetch_enable_o ( fetch_enable_o      ),
    .boot_addr_o    ( boot_addr_o         ),
    .bootmode_i     ( bootmode_i          )
  );

endmodule

// File: hdl/island_xbar.sv
// Masters-to-targets crossbar with per-target round-robin arbitration
`timescale 1ns/100ps

module island_xbar import island_pkg::*; #(
  parameter int unsigned NumIn  = NumMasters,
  parameter int unsigned NumOut = NumTargets
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     in_req_i    [NumIn],
  input  bus_req_t in_data_i   [NumIn],
  output logic     in_gnt_o    [NumIn],
  output logic     in_rvalid_o [NumIn],
  output bus_rsp_t in_rsp_o    [NumIn],

  output logic     out_req_o   [NumOut],
  output bus_req_t out_data_o  [NumOut],
  input  logic     out_gnt_i   [NumOut],
  input  bus_rsp_t out_rsp_i   [NumOut]
);

  localparam int unsigned IdxBits = (NumIn > 1) ? $clog2(NumIn) : 1;

  typedef logic [IdxBits-1:0] in_idx_t;

  logic [NumIn-1:0] req_mat   [NumOut];
  logic [NumIn-1:0] gnt_mat   [NumOut];
  logic [NumIn-1:0] gnt_seen  [NumOut];
  in_idx_t          win       [NumOut];
  in_idx_t          rr_q      [NumOut];
  logic             rsp_vld_q [NumOut];
  in_idx_t          rsp_src_q [NumOut];

  // -------------------------------------------------------------------
  // Request decode and arbitration
  // -------------------------------------------------------------------
  always_comb begin
    int cand;
    for (int t = 0; t < NumOut; t++) begin
      for (int i = 0; i < NumIn; i++) begin
        req_mat[t][i] = in_req_i[i] && (decode_target(in_data_i[i].addr) == tgt_idx_t'(t));
      end
    end
    for (int t = 0; t < NumOut; t++) begin
      // Walk backwards so the requester closest to the pointer wins
      win[t] = rr_q[t];
      for (int k = NumIn - 1; k >= 0; k--) begin
        cand = (int'(rr_q[t]) + k) % int'(NumIn);
        if (req_mat[t][cand]) begin
          win[t] = in_idx_t'(cand);
        end
      end
      out_req_o[t]       = |req_mat[t];
      out_data_o[t]      = in_data_i[win[t]];
      gnt_mat[t]         = '0;
      gnt_mat[t][win[t]] = out_req_o[t] && out_gnt_i[t];
    end
  end

  always_comb begin
    for (int i = 0; i < NumIn; i++) begin
      in_gnt_o[i] = 1'b0;
      for (int t = 0; t < NumOut; t++) begin
        in_gnt_o[i] = in_gnt_o[i] | gnt_mat[t][i];
      end
    end
  end

  // -------------------------------------------------------------------
  // Pointer update and response routing
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int t = 0; t < NumOut; t++) begin
        rr_q[t]      <= '0;
        rsp_vld_q[t] <= 1'b0;
        rsp_src_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < NumOut; t++) begin
        rsp_vld_q[t] <= out_req_o[t] && out_gnt_i[t];
        if (out_req_o[t] && out_gnt_i[t]) begin
          rsp_src_q[t] <= win[t];
          rr_q[t]      <= in_idx_t'((int'(win[t]) + 1) % int'(NumIn));
        end
      end
    end
  end

  // Targets answer one cycle after the grant
  always_comb begin
    for (int i = 0; i < NumIn; i++) begin
      in_rvalid_o[i] = 1'b0;
      in_rsp_o[i]    = '0;
    end
    for (int t = 0; t < NumOut; t++) begin
      if (rsp_vld_q[t]) begin
        in_rvalid_o[rsp_src_q[t]] = 1'b1;
        in_rsp_o[rsp_src_q[t]]    = out_rsp_i[t];
      end
    end
  end

  // Granted inputs per target, seen from the input side
  always_comb begin
    for (int t = 0; t < NumOut; t++) begin
      for (int i = 0; i < NumIn; i++) begin
        gnt_seen[t][i] = in_gnt_o[i] && req_mat[t][i];
      end
    end
  end

  for (genvar i = 0; i < NumIn; i++) begin : gen_in_check
    a_gnt_with_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_gnt_o[i] |-> in_req_i[i])
      else $error("xbar grant on input %0d without request", i);
  end

  for (genvar t = 0; t < NumOut; t++) begin : gen_out_check
    a_one_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_seen[t]))
      else $error("xbar target %0d granted to several inputs", t);
  end

endmodule

// File: hdl/island_periph_demux.sv
// Peripheral region demux with soc ctrl, boot ROM and the error target
`timescale 1ns/100ps

module island_periph_demux import island_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  bus_req_t             data_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output bus_rsp_t             rsp_o,
  output logic                 fetch_enable_o,
  output logic [AddrWidth-1:0] boot_addr_o,
  input  boot_mode_e           bootmode_i
);

  periph_sel_e sel;
  periph_sel_e sel_q;
  logic        soc_req;
  logic        rom_req;
  logic        soc_rvalid;
  logic        rom_rvalid;
  logic        err_rvalid_q;
  bus_rsp_t    soc_rsp;
  bus_rsp_t    rom_rsp;

  assign sel     = decode_periph(data_i.addr);
  assign soc_req = req_i && (sel == PERIPH_SOC_CTRL);
  assign rom_req = req_i && (sel == PERIPH_BOOTROM);

  // Every peripheral accepts at once
  assign gnt_o = req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q        <= PERIPH_ERROR;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= req_i && (sel == PERIPH_ERROR);
      if (req_i) begin
        sel_q <= sel;
      end
    end
  end

  island_soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i          ( soc_req        ),
    .data_i         ( data_i         ),
    .rvalid_o       ( soc_rvalid     ),
    .rsp_o          ( soc_rsp        ),
    .bootmode_i     ( bootmode_i     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  island_bootrom i_bootrom (
    .clk_i,
    .rst_ni,
    .req_i    ( rom_req    ),
    .data_i   ( data_i     ),
    .rvalid_o ( rom_rvalid ),
    .rsp_o    ( rom_rsp    )
  );

  assign rvalid_o = soc_rvalid | rom_rvalid | err_rvalid_q;

  always_comb begin
    case (sel_q)
      PERIPH_SOC_CTRL: rsp_o = soc_rsp;
      PERIPH_BOOTROM:  rsp_o = rom_rsp;
      default:         rsp_o = '{rdata: ErrorRdata, err: 1'b1};
    endcase
  end

  // Response timing holds across the soc ctrl and ROM paths
  a_rsp_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i |=> rvalid_o) and (rvalid_o |-> $past(req_i)))
    else $error("peripheral response not one cycle after request");

endmodule

// File: hdl/island_soc_ctrl.sv
// SoC control registers holding boot address, fetch enable and boot mode
`timescale 1ns/100ps

module island_soc_ctrl import island_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  bus_req_t             data_i,
  output logic                 rvalid_o,
  output bus_rsp_t             rsp_o,
  input  boot_mode_e           bootmode_i,
  output logic                 fetch_enable_o,
  output logic [AddrWidth-1:0] boot_addr_o
);

  logic                 first_cycle_q;
  logic [AddrWidth-1:0] boot_addr_q;
  logic                 fetch_en_q;
  boot_mode_e           boot_mode_q;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;
  logic [DataWidth-1:0] rdata_d;
  logic [AddrWidth-1:0] reg_off;

  assign reg_off = data_i.addr - (PeriphBase + SocCtrlOffset);

  // -------------------------------------------------------------------
  // Register write and hardware capture
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      boot_addr_q   <= BootAddrDefault;
      fetch_en_q    <= 1'b0;
      boot_mode_q   <= BOOT_JTAG;
      rvalid_q      <= 1'b0;
    end else begin
      first_cycle_q <= 1'b0;
      rvalid_q      <= req_i;
      if (first_cycle_q) begin
        // Boot straight away when debug is the boot source
        boot_mode_q <= bootmode_i;
        fetch_en_q  <= (bootmode_i == BOOT_JTAG);
      end else if (req_i && data_i.we) begin
        case (reg_off)
          RegBootAddr: begin
            for (int b = 0; b < BeWidth; b++) begin
              if (data_i.be[b]) begin
                boot_addr_q[8*b +: 8] <= data_i.wdata[8*b +: 8];
              end
            end
          end
          RegFetchEn: begin
            if (data_i.be[0]) begin
              fetch_en_q <= data_i.wdata[0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Read mux, boot mode is read only
  always_comb begin
    case (reg_off)
      RegBootAddr: rdata_d = boot_addr_q;
      RegFetchEn:  rdata_d = DataWidth'(fetch_en_q);
      RegBootMode: rdata_d = DataWidth'(boot_mode_q);
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rvalid_o       = rvalid_q;
  assign rsp_o          = '{rdata: rdata_q, err: 1'b0};
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

// File: hdl/island_bootrom.sv
// Boot code ROM loaded from a hex file, writes answer with an error
`timescale 1ns/100ps

module island_bootrom import island_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  bus_req_t data_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  logic [DataWidth-1:0]   rom [RomNumWords];
  logic [DataWidth-1:0]   rdata_q;
  logic                   err_q;
  logic                   rvalid_q;
  logic [RomAddrBits-1:0] word_idx;

  initial begin
    $readmemh(BootRomFile, rom);
  end

  // Contents repeat through the whole ROM range
  assign word_idx = data_i.addr[ByteOffBits +: RomAddrBits];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom[word_idx];
      err_q   <= data_i.we;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: err_q};

endmodule

// File: hdl/island_sram_bank.sv
// Word-wide SRAM bank with byte enables and a registered response
`timescale 1ns/100ps

module island_sram_bank import island_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  bus_req_t data_i,
  output logic     gnt_o,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  localparam int unsigned NumWords = 2 ** BankAddrBits;

  logic [DataWidth-1:0]    mem_q [NumWords];
  logic [DataWidth-1:0]    rdata_q;
  logic [BankAddrBits-1:0] word_addr;
  logic                    rvalid_q;

  assign word_addr = data_i.addr[ByteOffBits +: BankAddrBits];
  assign gnt_o     = req_i;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (data_i.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (data_i.be[b]) begin
            mem_q[word_addr][8*b +: 8] <= data_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};

endmodule

// File: hdl/island_pkg.sv
// Island bus types, address map, boot modes and the address decode functions
package island_pkg;

  // -------------------------------------------------------------------
  // Bus geometry
  // -------------------------------------------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned ByteOffBits = $clog2(BeWidth);

  localparam int unsigned NumMasters = 2;
  localparam int unsigned NumTargets = 3;
  localparam int unsigned TgtIdxBits = $clog2(NumTargets);

  // Crossbar target indices, banks follow each other
  localparam int unsigned TgtPeriph = 0;
  localparam int unsigned TgtBank0  = 1;
  localparam int unsigned NumBanks  = 2;

  localparam int unsigned BankNumBytes = 4096;
  localparam int unsigned BankAddrBits = $clog2(BankNumBytes / BeWidth);

  // -------------------------------------------------------------------
  // Address map
  // -------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] IslandBase    = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] PeriphBase    = 32'h0020_0000;
  localparam logic [AddrWidth-1:0] SocCtrlOffset = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] SocCtrlRange  = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] BootRomOffset = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] BootRomRange  = 32'h0000_1000;

  localparam int unsigned RomNumWords = 16;
  localparam int unsigned RomAddrBits = $clog2(RomNumWords);
  localparam string       BootRomFile = "hdl/island_bootrom.hex";

  localparam logic [DataWidth-1:0] ErrorRdata = 32'hBADC_AB1E;

  // SoC control register offsets
  localparam logic [AddrWidth-1:0] RegBootAddr = 32'h0;
  localparam logic [AddrWidth-1:0] RegFetchEn  = 32'h4;
  localparam logic [AddrWidth-1:0] RegBootMode = 32'h8;

  localparam logic [AddrWidth-1:0] BootAddrDefault = PeriphBase + BootRomOffset;

  typedef enum logic [1:0] {
    BOOT_JTAG = 2'd0,
    BOOT_SPI  = 2'd1,
    BOOT_UART = 2'd2
  } boot_mode_e;

  typedef enum logic [1:0] {
    PERIPH_ERROR    = 2'd0,
    PERIPH_SOC_CTRL = 2'd1,
    PERIPH_BOOTROM  = 2'd2
  } periph_sel_e;

  typedef logic [TgtIdxBits-1:0] tgt_idx_t;

  typedef struct packed {
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // Anything outside the banks falls to the peripheral path
  function automatic tgt_idx_t decode_target(input logic [AddrWidth-1:0] addr);
    logic [AddrWidth-1:0] off;
    off = addr - IslandBase;
    if (off < NumBanks * BankNumBytes) begin
      return tgt_idx_t'(TgtBank0 + off / BankNumBytes);
    end
    return tgt_idx_t'(TgtPeriph);
  endfunction

  function automatic periph_sel_e decode_periph(input logic [AddrWidth-1:0] addr);
    logic [AddrWidth-1:0] off;
    off = addr - PeriphBase;
    if ((off - SocCtrlOffset) < SocCtrlRange) begin
      return PERIPH_SOC_CTRL;
    end
    if ((off - BootRomOffset) < BootRomRange) begin
      return PERIPH_BOOTROM;
    end
    return PERIPH_ERROR;
  endfunction

endpackage
